/* Makefile */
# Verilator flow for the sample playback buffer

TOP       ?= tb_sample_buffer
FILELIST  ?= sample_buffer_top.f
VERILATOR ?= verilator
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* sample_buffer_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_buffer_asserts (
    input wire                             aximm,
    input wire                             rst_n,
    input wire                             rd_issue,
    input wire                             credit_ok,
    input wire sample_buffer_pkg::credit_t credit_cnt,
    input wire                             sample_valid,
    // High only where bound into the output stage
    input wire                             pipe_en,
    input wire                             play_start,
    input wire                             play_idle
);
    import sample_buffer_pkg::*;

    // A read spends a credit, so one must be free
    issue_needs_credit: assert property (@(posedge aximm) disable iff (!rst_n)
        pipe_en && rd_issue |-> credit_ok) else $error("read issued with no credit");

    credit_bounded: assert property (@(posedge aximm) disable iff (!rst_n)
        pipe_en |-> credit_cnt <= credit_t'(CREDIT_MAX))
        else $error("credit count above slot count");

    ////////////////////////////////////////
    // Two cycle read pipeline
    ////////////////////////////////////////
    valid_after_issue: assert property (@(posedge aximm) disable iff (!rst_n)
        pipe_en && $past(rd_issue, 2) |-> sample_valid) else $error("issued read lost");

    valid_needs_issue: assert property (@(posedge aximm) disable iff (!rst_n)
        pipe_en && sample_valid |-> $past(rd_issue, 2)) else $error("valid without read");

    // Idle with no start means no read in the next cycle
    idle_no_issue: assert property (@(posedge aximm) disable iff (!rst_n)
        $past(play_idle) && !$past(play_start) |-> !rd_issue)
        else $error("read issued while idle");

endmodule

bind sample_credit_out sample_buffer_asserts credit_asserts_i (
    .aximm(aximm), .rst_n(rst_n), .rd_issue(rd_issue), .credit_ok(credit_ok),
    .credit_cnt(credit_cnt), .sample_valid(sample_valid), .pipe_en(1'b1),
    .play_start(1'b0), .play_idle(1'b0)
);

bind sample_playback sample_buffer_asserts playback_asserts_i (
    .aximm(aximm), .rst_n(rst_n), .rd_issue(rd_issue), .credit_ok(credit_ok),
    .credit_cnt('0), .sample_valid(1'b0), .pipe_en(1'b0), .play_start(play_start),
    .play_idle(state == sample_buffer_pkg::PLAY_IDLE)
);

`default_nettype wire

/* sample_buffer_pkg.sv */
`default_nettype none

package sample_buffer_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // One output sample
    localparam int SAMPLE_W      = 16;
    // One host word, two samples
    localparam int WORD_W        = 32;
    // 64 host words
    localparam int WORD_ADDR_W   = 6;
    // 128 samples
    localparam int SAMPLE_ADDR_W = 7;
    localparam int REG_ADDR_W    = 2;

    // Receiver slots, also the credit count out of reset
    localparam int CREDIT_MAX = 4;
    localparam int CREDIT_W   = 3;

    typedef logic [SAMPLE_W-1:0]      sample_t;
    typedef logic [WORD_W-1:0]        word_t;
    typedef logic [WORD_ADDR_W-1:0]   word_addr_t;
    typedef logic [SAMPLE_ADDR_W-1:0] sample_addr_t;
    typedef logic [REG_ADDR_W-1:0]    reg_addr_t;
    typedef logic [CREDIT_W-1:0]      credit_t;

    ////////////////////////////////////////
    // Register map
    ////////////////////////////////////////
    localparam reg_addr_t REG_CTRL  = 2'd0;
    localparam reg_addr_t REG_START = 2'd1;
    localparam reg_addr_t REG_END   = 2'd2;

    // Bit positions in REG_CTRL
    localparam int CTRL_ACTIVE   = 0;
    localparam int CTRL_ONE_SHOT = 1;

    // Playback sequencer states
    typedef enum logic {
        PLAY_IDLE,
        PLAY_RUN
    } play_state_t;

endpackage

`default_nettype wire

/* sample_buffer_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_buffer_ram (
    input  wire                                  aximm,
    input  wire                                  wr_en,
    input  wire sample_buffer_pkg::word_addr_t   wr_addr,
    input  wire sample_buffer_pkg::word_t        wr_data,
    input  wire sample_buffer_pkg::sample_addr_t rd_addr,
    output sample_buffer_pkg::sample_t           rd_data
);
    import sample_buffer_pkg::*;

    localparam int DEPTH = 1 << WORD_ADDR_W;

    word_t mem [DEPTH];
    word_t rd_word;
    logic  rd_half;

    ////////////////////////////////////////
    // Host write port
    ////////////////////////////////////////

    // Full words only, no byte enables
    always_ff @(posedge aximm) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // Sample read port
    ////////////////////////////////////////

    // Word index is the sample address without its low bit
    always_ff @(posedge aximm) begin
        rd_word <= mem[rd_addr[SAMPLE_ADDR_W-1:1]];
        rd_half <= rd_addr[0];
    end

    // Even sample in the low half, odd in the high half
    always_comb begin
        if (rd_half) begin
            rd_data = rd_word[WORD_W-1:SAMPLE_W];
        end else begin
            rd_data = rd_word[SAMPLE_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* sample_buffer_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_buffer_regs (
    input  wire                                aximm,
    input  wire                                rst_n,
    input  wire                                reg_wr_en,
    input  wire sample_buffer_pkg::reg_addr_t  reg_wr_addr,
    input  wire sample_buffer_pkg::word_t      reg_wr_data,
    input  wire sample_buffer_pkg::reg_addr_t  reg_rd_addr,
    input  wire                                play_done,
    output sample_buffer_pkg::word_t           reg_rdata,
    output logic                               play_start,
    output logic                               play_stop,
    output logic                               one_shot,
    output sample_buffer_pkg::sample_addr_t    start_offset,
    output sample_buffer_pkg::sample_addr_t    end_offset
);
    import sample_buffer_pkg::*;

    logic  active;
    logic  wr_active;
    word_t rd_mux;

    // Active bit as carried by a control write
    assign wr_active = reg_wr_data[CTRL_ACTIVE];

    ////////////////////////////////////////
    // Register writes and start/stop pulses
    ////////////////////////////////////////
    always_ff @(posedge aximm) begin
        if (!rst_n) begin
            active       <= 1'b0;
            one_shot     <= 1'b0;
            start_offset <= '0;
            // Whole buffer by default
            end_offset   <= '1;
            play_start   <= 1'b0;
            play_stop    <= 1'b0;
        end else begin
            // Single cycle pulses
            play_start <= 1'b0;
            play_stop  <= 1'b0;
            // One-shot pass finished
            if (play_done) begin
                active <= 1'b0;
            end
            if (reg_wr_en) begin
                case (reg_wr_addr)
                    REG_CTRL: begin
                        active     <= wr_active;
                        one_shot   <= reg_wr_data[CTRL_ONE_SHOT];
                        // Done in the same cycle counts as already inactive
                        play_start <= (!active || play_done) && wr_active;
                        play_stop  <= active && !play_done && !wr_active;
                    end
                    REG_START: begin
                        start_offset <= reg_wr_data[SAMPLE_ADDR_W-1:0];
                    end
                    REG_END: begin
                        end_offset <= reg_wr_data[SAMPLE_ADDR_W-1:0];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Readback select
    always_comb begin
        rd_mux = '0;
        case (reg_rd_addr)
            REG_CTRL: begin
                rd_mux[CTRL_ACTIVE]   = active;
                rd_mux[CTRL_ONE_SHOT] = one_shot;
            end
            REG_START: rd_mux[SAMPLE_ADDR_W-1:0] = start_offset;
            REG_END:   rd_mux[SAMPLE_ADDR_W-1:0] = end_offset;
            // Unmapped index reads zero
            default: ;
        endcase
    end

    // One cycle read latency
    always_ff @(posedge aximm) begin
        reg_rdata <= rd_mux;
    end

endmodule

`default_nettype wire

/* sample_buffer_top.f */
sample_buffer_pkg.sv
sample_buffer_regs.sv
sample_buffer_ram.sv
sample_playback.sv
sample_credit_out.sv
sample_buffer_top.sv
sample_buffer_asserts.sv
tb_sample_buffer.sv

/* sample_buffer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_buffer_top (
    input  wire                                 aximm,
    input  wire                                 rst_n,
    // Host memory write
    input  wire                                 mem_wr_en,
    input  wire sample_buffer_pkg::word_addr_t  mem_wr_addr,
    input  wire sample_buffer_pkg::word_t       mem_wr_data,
    // Host register access
    input  wire                                 reg_wr_en,
    input  wire sample_buffer_pkg::reg_addr_t   reg_wr_addr,
    input  wire sample_buffer_pkg::word_t       reg_wr_data,
    input  wire sample_buffer_pkg::reg_addr_t   reg_rd_addr,
    output sample_buffer_pkg::word_t            reg_rdata,
    // Output stream with credit return
    input  wire                                 credit_return,
    output logic                                sample_valid,
    output sample_buffer_pkg::sample_t          sample_data,
    output logic                                sample_last
);
    import sample_buffer_pkg::*;

    // Control from the register block
    logic         play_start;
    logic         play_stop;
    logic         play_done;
    logic         one_shot;
    sample_addr_t start_offset;
    sample_addr_t end_offset;

    // Read path
    logic         rd_issue;
    sample_addr_t rd_addr;
    logic         rd_last;
    sample_t      rd_data;
    logic         credit_ok;

    ////////////////////////////////////////
    // Input side
    ////////////////////////////////////////
    sample_buffer_regs regs_i (
        .aximm, .rst_n, .reg_wr_en, .reg_wr_addr, .reg_wr_data, .reg_rd_addr,
        .play_done, .reg_rdata, .play_start, .play_stop, .one_shot,
        .start_offset, .end_offset
    );

    // Buffer memory
    sample_buffer_ram ram_i (
        .aximm, .wr_en(mem_wr_en), .wr_addr(mem_wr_addr), .wr_data(mem_wr_data),
        .rd_addr, .rd_data
    );

    // Playback sequencer
    sample_playback playback_i (
        .aximm, .rst_n, .play_start, .play_stop, .one_shot, .start_offset,
        .end_offset, .credit_ok, .rd_issue, .rd_addr, .rd_last, .play_done
    );

    ////////////////////////////////////////
    // Output side
    ////////////////////////////////////////
    sample_credit_out credit_i (
        .aximm, .rst_n, .rd_issue, .rd_last, .rd_data, .credit_return,
        .credit_ok, .sample_valid, .sample_data, .sample_last
    );

endmodule

`default_nettype wire

/* sample_credit_out.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_credit_out (
    input  wire                             aximm,
    input  wire                             rst_n,
    input  wire                             rd_issue,
    input  wire                             rd_last,
    input  wire sample_buffer_pkg::sample_t rd_data,
    input  wire                             credit_return,
    output logic                            credit_ok,
    output logic                            sample_valid,
    output sample_buffer_pkg::sample_t      sample_data,
    output logic                            sample_last
);
    import sample_buffer_pkg::*;

    credit_t credit_cnt;
    credit_t credit_nxt;
    logic    issue_d;
    logic    last_d;

    ////////////////////////////////////////
    // Credit counter
    ////////////////////////////////////////

    // Any free receiver slot allows a read
    assign credit_ok = (credit_cnt != '0);

    always_comb begin
        credit_nxt = credit_cnt;
        case ({rd_issue, credit_return})
            // Spend one
            2'b10: credit_nxt = credit_cnt - 1'b1;
            // Return one, saturate at the slot count
            2'b01: begin
                if (credit_cnt < credit_t'(CREDIT_MAX)) begin
                    credit_nxt = credit_cnt + 1'b1;
                end
            end
            // Spend and return cancel out
            default: ;
        endcase
    end

    always_ff @(posedge aximm) begin
        if (!rst_n) begin
            credit_cnt <= credit_t'(CREDIT_MAX);
        end else begin
            credit_cnt <= credit_nxt;
        end
    end

    ////////////////////////////////////////
    // Output pipeline
    ////////////////////////////////////////

    // Flags wait one cycle for the RAM data
    always_ff @(posedge aximm) begin
        if (!rst_n) begin
            issue_d      <= 1'b0;
            last_d       <= 1'b0;
            sample_valid <= 1'b0;
            sample_last  <= 1'b0;
        end else begin
            issue_d      <= rd_issue;
            last_d       <= rd_last;
            sample_valid <= issue_d;
            sample_last  <= issue_d && last_d;
        end
    end

    // Payload register, loaded with each valid sample
    always_ff @(posedge aximm) begin
        if (issue_d) begin
            sample_data <= rd_data;
        end
    end

endmodule

`default_nettype wire

/* sample_playback.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_playback (
    input  wire                                  aximm,
    input  wire                                  rst_n,
    input  wire                                  play_start,
    input  wire                                  play_stop,
    input  wire                                  one_shot,
    input  wire sample_buffer_pkg::sample_addr_t start_offset,
    input  wire sample_buffer_pkg::sample_addr_t end_offset,
    input  wire                                  credit_ok,
    output logic                                 rd_issue,
    output sample_buffer_pkg::sample_addr_t      rd_addr,
    output logic                                 rd_last,
    output logic                                 play_done
);
    import sample_buffer_pkg::*;

    play_state_t  state;
    sample_addr_t ptr;
    logic         at_end;

    ////////////////////////////////////////
    // Read issue
    ////////////////////////////////////////

    // Final sample of the pass
    assign at_end = (ptr == end_offset);

    // One read per cycle while a credit is free
    // A stop blocks the read in its own cycle
    assign rd_issue = (state == PLAY_RUN) && credit_ok && !play_stop;
    assign rd_addr  = ptr;
    assign rd_last  = rd_issue && at_end;

    ////////////////////////////////////////
    // Sequencer FSM
    ////////////////////////////////////////
    always_ff @(posedge aximm) begin
        if (!rst_n) begin
            state     <= PLAY_IDLE;
            ptr       <= '0;
            play_done <= 1'b0;
        end else begin
            play_done <= 1'b0;
            case (state)
                PLAY_IDLE: begin
                    // First read comes the cycle after the start
                    if (play_start) begin
                        ptr   <= start_offset;
                        state <= PLAY_RUN;
                    end
                end
                PLAY_RUN: begin
                    if (play_start) begin
                        // Restart from the top of the range
                        ptr <= start_offset;
                    end else if (play_stop) begin
                        // Reads in flight drain through the output stage
                        state <= PLAY_IDLE;
                    end else if (rd_issue) begin
                        if (!at_end) begin
                            // Wraps through the top of the buffer by itself
                            ptr <= ptr + 1'b1;
                        end else if (one_shot) begin
                            state     <= PLAY_IDLE;
                            play_done <= 1'b1;
                        end else begin
                            // Loop mode
                            ptr <= start_offset;
                        end
                    end
                    // No credit: hold the address
                end
                default: begin
                    state <= PLAY_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* tb_sample_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sample_buffer;
    import sample_buffer_pkg::*;

    // About 850 samples at up to 4 cycles each with 12 cycle credit delays,
    // plus register and fill traffic, then five times that for margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic       aximm;
    logic       rst_n;
    logic       mem_wr_en;
    word_addr_t mem_wr_addr;
    word_t      mem_wr_data;
    logic       reg_wr_en;
    reg_addr_t  reg_wr_addr;
    word_t      reg_wr_data;
    reg_addr_t  reg_rd_addr;
    word_t      reg_rdata;
    logic       credit_return;
    logic       sample_valid;
    sample_t    sample_data;
    logic       sample_last;

    integer seed = 84;
    int     checks;
    int     errors;
    int     cycle_count;
    // Longest credit return delay, and samples the receiver holds
    int     ret_delay_max;
    int     held;

    word_t   mem_model [1 << WORD_ADDR_W];
    sample_t exp_seq [$];
    sample_t rx_data [$];
    logic    rx_last [$];
    int      rel_cycle [$];

    sample_buffer_top dut_i (
        .aximm, .rst_n, .mem_wr_en, .mem_wr_addr, .mem_wr_data, .reg_wr_en, .reg_wr_addr,
        .reg_wr_data, .reg_rd_addr, .reg_rdata, .credit_return, .sample_valid,
        .sample_data, .sample_last
    );

    initial begin
        aximm = 1'b0;
        forever #10 aximm = ~aximm;
    end

    ////////////////////////////////////////
    // Receiver with CREDIT_MAX slots
    ////////////////////////////////////////
    initial begin
        int rx_cycle;
        int delay;
        rx_cycle = 0;
        credit_return = 1'b0;
        forever begin
            @(posedge aximm);
            rx_cycle++;
            if (sample_valid === 1'b1) begin
                held++;
                if (held > CREDIT_MAX) begin
                    errors++;
                    $display("ERROR: sample arrived with no free receiver slot (%0d held)", held);
                end
                rx_data.push_back(sample_data);
                rx_last.push_back(sample_last);
                delay = {$random(seed)} % (ret_delay_max + 1);
                rel_cycle.push_back(rx_cycle + delay);
            end
            // Slots free in arrival order, one credit per cycle
            if (rel_cycle.size() > 0 && rel_cycle[0] <= rx_cycle) begin
                void'(rel_cycle.pop_front());
                held--;
                credit_return <= 1'b1;
            end else begin
                credit_return <= 1'b0;
            end
        end
    end

    task automatic report_counts();
        $display("Checks run: %0d, errors: %0d", checks, errors);
    endtask

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge aximm);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        report_counts();
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // Host access
    ////////////////////////////////////////
    task automatic write_reg(input reg_addr_t addr, input word_t data);
        @(posedge aximm);
        reg_wr_en   <= 1'b1;
        reg_wr_addr <= addr;
        reg_wr_data <= data;
        @(posedge aximm);
        reg_wr_en <= 1'b0;
    endtask

    // Data is registered one cycle after the address is seen
    task automatic read_reg(input reg_addr_t addr, output word_t data);
        @(posedge aximm);
        reg_rd_addr <= addr;
        @(posedge aximm);
        @(negedge aximm);
        data = reg_rdata;
    endtask

    task automatic fill_memory();
        int    k;
        word_t w;
        for (k = 0; k < (1 << WORD_ADDR_W); k++) begin
            w = $random(seed);
            mem_model[k] = w;
            @(posedge aximm);
            mem_wr_en   <= 1'b1;
            mem_wr_addr <= word_addr_t'(k);
            mem_wr_data <= w;
        end
        @(posedge aximm);
        mem_wr_en <= 1'b0;
    endtask

    ////////////////////////////////////////
    // Playback model
    ////////////////////////////////////////

    // Sample 2k is the low half of word k
    function automatic sample_t model_sample(input sample_addr_t a);
        word_t w;
        w = mem_model[a[SAMPLE_ADDR_W-1:1]];
        if (a[0]) begin
            return w[31:16];
        end
        return w[15:0];
    endfunction

    // One pass from start to end, modulo the buffer depth
    task automatic build_sequence(input sample_addr_t start_off, input sample_addr_t end_off);
        sample_addr_t a;
        exp_seq.delete();
        a = start_off;
        exp_seq.push_back(model_sample(a));
        while (a != end_off) begin
            a = a + 7'd1;
            exp_seq.push_back(model_sample(a));
        end
        rx_data.delete();
        rx_last.delete();
    endtask

    task automatic wait_samples(input int n);
        while (rx_data.size() < n) begin
            @(negedge aximm);
        end
    endtask

    // Pipeline empty and every credit handed back
    task automatic wait_drain();
        int quiet;
        quiet = 0;
        while (quiet < 8) begin
            @(negedge aximm);
            if (held == 0 && sample_valid !== 1'b1) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    task automatic run_one_shot(input string name, input sample_addr_t start_off,
                                input sample_addr_t end_off);
        int i;
        build_sequence(start_off, end_off);
        write_reg(REG_START, 32'(start_off));
        write_reg(REG_END, 32'(end_off));
        write_reg(REG_CTRL, 32'h3);
        wait_samples(exp_seq.size());
        wait_drain();
        check_value({name, " count"}, exp_seq.size(), rx_data.size());
        for (i = 0; i < exp_seq.size() && i < rx_data.size(); i++) begin
            check_value($sformatf("%s data %0d", name, i), 32'(exp_seq[i]), 32'(rx_data[i]));
            check_value($sformatf("%s last %0d", name, i), 32'(i == exp_seq.size() - 1),
                        32'(rx_last[i]));
        end
    endtask

    // Received stream must be a prefix of the repeating pass
    task automatic run_loop(input string name, input sample_addr_t start_off,
                            input sample_addr_t end_off, input int passes);
        int i;
        int n;
        int len;
        int target;
        word_t v;
        build_sequence(start_off, end_off);
        len = exp_seq.size();
        target = passes * len + 3;
        write_reg(REG_START, 32'(start_off));
        write_reg(REG_END, 32'(end_off));
        write_reg(REG_CTRL, 32'h1);
        // Active reads back while the loop runs
        read_reg(REG_CTRL, v);
        check_value({name, " ctrl running"}, 32'h1, v);
        wait_samples(target);
        write_reg(REG_CTRL, 32'h0);
        wait_drain();
        n = rx_data.size();
        repeat (20) @(negedge aximm);
        check_value({name, " no samples after drain"}, n, rx_data.size());
        // Only reads in flight or issued before the stop took effect
        check_value({name, " samples after stop"}, 1, 32'(n <= target + CREDIT_MAX));
        for (i = 0; i < n; i++) begin
            check_value($sformatf("%s data %0d", name, i), 32'(exp_seq[i % len]),
                        32'(rx_data[i]));
            check_value($sformatf("%s last %0d", name, i), 32'((i % len) == len - 1),
                        32'(rx_last[i]));
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        word_t        v;
        word_t        wr;
        sample_addr_t start_off;
        sample_addr_t end_off;
        int           i;
        rst_n         = 1'b0;
        mem_wr_en     = 1'b0;
        mem_wr_addr   = '0;
        mem_wr_data   = '0;
        reg_wr_en     = 1'b0;
        reg_wr_addr   = '0;
        reg_wr_data   = '0;
        reg_rd_addr   = '0;
        ret_delay_max = 0;
        repeat (2) @(posedge aximm);
        rst_n <= 1'b1;

        // Reset defaults, end offset covers the whole buffer
        read_reg(REG_CTRL, v);
        check_value("reset ctrl", 32'h0, v);
        read_reg(REG_START, v);
        check_value("reset start", 32'h0, v);
        read_reg(REG_END, v);
        check_value("reset end", 32'h7f, v);
        read_reg(2'd3, v);
        check_value("unmapped reg", 32'h0, v);

        for (i = 0; i < 8; i++) begin
            wr = $random(seed);
            write_reg(REG_START, wr);
            read_reg(REG_START, v);
            check_value("readback start", 32'(wr[SAMPLE_ADDR_W-1:0]), v);
            wr = $random(seed);
            write_reg(REG_END, wr);
            read_reg(REG_END, v);
            check_value("readback end", 32'(wr[SAMPLE_ADDR_W-1:0]), v);
            // Active kept low so nothing plays
            wr = $random(seed);
            wr[CTRL_ACTIVE] = 1'b0;
            write_reg(REG_CTRL, wr);
            read_reg(REG_CTRL, v);
            check_value("readback ctrl", 32'(wr[CTRL_ONE_SHOT]) << CTRL_ONE_SHOT, v);
        end

        fill_memory();
        run_one_shot("one_shot_full", 7'd0, 7'd127);
        read_reg(REG_CTRL, v);
        check_value("one_shot_full active", 32'h0, 32'(v[CTRL_ACTIVE]));

        start_off = sample_addr_t'({$random(seed)} % 128);
        end_off   = sample_addr_t'({$random(seed)} % 128);
        run_loop("loop_random", start_off, end_off, 2);

        // Start near the top, end near the bottom
        start_off = 7'd127 - sample_addr_t'({$random(seed)} % 20);
        end_off   = sample_addr_t'({$random(seed)} % 20);
        run_one_shot("wrap", start_off, end_off);
        check_value("wrap length", 129 - int'(start_off) + int'(end_off), rx_data.size());

        // Slow receiver
        ret_delay_max = 12;
        run_one_shot("backpressure_full", 7'd0, 7'd127);
        start_off = sample_addr_t'({$random(seed)} % 128);
        end_off   = sample_addr_t'({$random(seed)} % 128);
        run_one_shot("backpressure_range", start_off, end_off);
        run_loop("backpressure_loop", start_off, end_off, 1);

        report_counts();
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
